/* rv_decoder.f */
+incdir+testbench
source/rv_decode_pkg.sv
source/rv_alu_decode.sv
source/rv_lsu_decode.sv
source/rv_bru_decode.sv
source/rv_csr_decode.sv
source/rv_imm_gen.sv
source/rv_uop_merge.sv
source/rv_decoder.sv
testbench/tb_rv_decoder.sv

/* Makefile */
TOP := tb_rv_decoder

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --assert -f rv_decoder.f --top-module $(TOP)

# the log search decides pass or fail
sim:
	verilator --binary --timing --assert -f rv_decoder.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log

/* testbench/tb_rv_decoder_model.svh */
`ifndef TB_RV_DECODER_MODEL_SVH
`define TB_RV_DECODER_MODEL_SVH

// expected micro-op as seen on the uop outputs
typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] pc;
    fu_t             fu;
    op_t             op;
    reg_t            rs1;
    reg_t            rs2;
    reg_t            rd;
    logic            use_pc;
    logic            use_imm;
    logic [XLEN-1:0] imm;
} uop_t;

// SUB only exists in the register form
function automatic op_t expect_alu_op(input logic [2:0] f3, input logic alt,
                                      input logic reg_form);
    op_t op;
    case (f3)
        3'd0    : op = (reg_form && alt) ? _SUB : _ADD;
        3'd1    : op = _SLL;
        3'd2    : op = _LT;
        3'd3    : op = _LTU;
        3'd4    : op = _XOR;
        3'd5    : op = alt ? _SRA : _SRL;
        3'd6    : op = _OR;
        default : op = _AND;
    endcase
    return op;
endfunction

function automatic logic [XLEN-1:0] expect_imm(input logic [INST_W-1:0] inst);
    logic [XLEN-1:0] imm;
    case (inst[6:0])
        ITYPE_OP, LOAD_OP, JALR_OP, SYSTEM_OP :
            imm = {{20{inst[31]}}, inst[31:20]};
        STYPE_OP :
            imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
        BTYPE_OP :
            imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
        LUI_OP, AUIPC_OP :
            imm = {inst[31:12], 12'h000};
        JAL_OP :
            imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
        default :
            imm = '0;
    endcase
    return imm;
endfunction

// all zero when the fetch is not valid
function automatic uop_t expect_uop(input logic valid, input logic [INST_W-1:0] inst,
                                    input logic [XLEN-1:0] pc);
    uop_t       u;
    logic [2:0] f3;
    logic       r1;
    logic       r2;
    logic       wr;
    u  = '0;
    f3 = inst[14:12];
    r1 = 1'b0;
    r2 = 1'b0;
    wr = 1'b0;
    if (valid) begin
        u.valid = 1'b1;
        u.pc    = pc;
        case (inst[6:0])
            RTYPE_OP : begin
                {r1, r2, wr} = 3'b111;
                if (inst[25]) begin
                    u.fu = GMUL;
                    case (f3)
                        3'd0    : u.op = _MUL;
                        3'd1    : u.op = _MULH;
                        3'd2    : u.op = _MULHSU;
                        3'd3    : u.op = _MULHU;
                        default : u.op = _ADD;
                    endcase
                end else begin
                    u.fu = GALU;
                    u.op = expect_alu_op(f3, inst[30], 1'b1);
                end
            end
            ITYPE_OP : begin
                {r1, wr}  = 2'b11;
                u.fu      = GALU;
                u.use_imm = 1'b1;
                u.op      = expect_alu_op(f3, inst[30], 1'b0);
            end
            LUI_OP, AUIPC_OP : begin
                wr        = 1'b1;
                u.fu      = GALU;
                u.use_imm = 1'b1;
                u.use_pc  = (inst[6:0] == AUIPC_OP);
            end
            LOAD_OP : begin
                {r1, wr}  = 2'b11;
                u.fu      = GLSU;
                u.use_imm = 1'b1;
                case (f3)
                    3'd0    : u.op = _LB;
                    3'd1    : u.op = _LH;
                    3'd2    : u.op = _LW;
                    3'd4    : u.op = _LBU;
                    3'd5    : u.op = _LHU;
                    default : u.op = _ADD;
                endcase
            end
            STYPE_OP : begin
                {r1, r2}  = 2'b11;
                u.fu      = GLSU;
                u.use_imm = 1'b1;
                case (f3)
                    3'd0    : u.op = _SB;
                    3'd1    : u.op = _SH;
                    3'd2    : u.op = _SW;
                    default : u.op = _ADD;
                endcase
            end
            BTYPE_OP : begin
                {r1, r2}  = 2'b11;
                u.fu      = BRU;
                u.use_imm = 1'b1;
                case (f3)
                    3'd0    : u.op = _EQ;
                    3'd1    : u.op = _NE;
                    3'd4    : u.op = _LT;
                    3'd5    : u.op = _GE;
                    3'd6    : u.op = _LTU;
                    3'd7    : u.op = _GEU;
                    default : u.op = _ADD;
                endcase
            end
            JAL_OP, JALR_OP : begin
                wr        = 1'b1;
                r1        = (inst[6:0] == JALR_OP);
                u.fu      = BRU;
                u.use_pc  = 1'b1;
                u.use_imm = 1'b1;
                u.op      = r1 ? _JALR : _JAL;
            end
            SYSTEM_OP : begin
                {r1, wr}  = 2'b11;
                u.fu      = CSR;
                // bit 2 of funct3 marks the zimm forms
                // funct3 4 is reserved
                u.use_imm = f3[2] && (f3[1:0] != 2'b00);
                case (f3[1:0])
                    2'd1    : u.op = _CSRRW;
                    2'd2    : u.op = _CSRRS;
                    2'd3    : u.op = _CSRRC;
                    default : begin
                        if (f3 == 3'd0 && inst[31:20] == 12'h302) begin
                            u.op = _MRET;
                        end else if (f3 == 3'd0 && inst[31:20] == 12'h105) begin
                            u.op = _WFI;
                        end
                    end
                endcase
            end
            default : u.fu = NONE;
        endcase
        u.rs1 = r1 ? reg_t'(inst[19:15]) : X0;
        u.rs2 = r2 ? reg_t'(inst[24:20]) : X0;
        u.rd  = wr ? reg_t'(inst[11:7]) : X0;
        u.imm = u.use_imm ? expect_imm(inst) : '0;
    end
    return u;
endfunction

`endif

/* testbench/tb_rv_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rv_decoder import rv_decode_pkg::*; ();

    `include "tb_rv_decoder_model.svh"

    localparam int RESET_CYCLES   = 5;
    localparam int RANDOM_CYCLES  = 1500;
    // reset plus random run plus directed tail with margin
    localparam int TIMEOUT_CYCLES = 2000;

    logic              clk;
    logic              arst_n;
    logic              fetch_valid;
    logic [INST_W-1:0] fetch_inst;
    logic [XLEN-1:0]   fetch_pc;
    logic              uop_valid;
    logic [XLEN-1:0]   uop_pc;
    fu_t               uop_fu;
    op_t               uop_op;
    reg_t              uop_rs1;
    reg_t              uop_rs2;
    reg_t              uop_rd;
    logic              uop_use_pc;
    logic              uop_use_imm;
    logic [XLEN-1:0]   uop_imm;

    // fetch as sampled by the DUT on the last edge
    logic              prev_valid;
    logic [INST_W-1:0] prev_inst;
    logic [XLEN-1:0]   prev_pc;
    uop_t              model_uop;

    integer seed;
    int     cycles = 0;
    int     errors = 0;

    rv_decoder u_rv_decoder (
        .clk         (clk),
        .arst_n      (arst_n),
        .fetch_valid (fetch_valid),
        .fetch_inst  (fetch_inst),
        .fetch_pc    (fetch_pc),
        .uop_valid   (uop_valid),
        .uop_pc      (uop_pc),
        .uop_fu      (uop_fu),
        .uop_op      (uop_op),
        .uop_rs1     (uop_rs1),
        .uop_rs2     (uop_rs2),
        .uop_rd      (uop_rd),
        .uop_use_pc  (uop_use_pc),
        .uop_use_imm (uop_use_imm),
        .uop_imm     (uop_imm)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: stimulus still running after %0d cycles", cycles);
            $display("Done: errors found");
            $fatal(1);
        end
    end

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            prev_valid <= 1'b0;
            prev_inst  <= '0;
            prev_pc    <= '0;
        end else begin
            prev_valid <= fetch_valid;
            prev_inst  <= fetch_inst;
            prev_pc    <= fetch_pc;
        end
    end

    always_comb model_uop = expect_uop(prev_valid, prev_inst, prev_pc);

    task automatic report_mismatch(input string name, input logic [31:0] want,
                                   input logic [31:0] got);
        errors++;
        $display("error at %0t ns: %s expected %0h actual %0h", $time, name, want, got);
        $display("Done: errors found");
        $fatal(1);
    endtask

    // --------------------
    // checks
    // --------------------
    // outputs settle long before the falling edge
    assert property (@(negedge clk) uop_valid == model_uop.valid)
        else report_mismatch("uop_valid", 32'(model_uop.valid), 32'(uop_valid));
    assert property (@(negedge clk) uop_pc == model_uop.pc)
        else report_mismatch("uop_pc", model_uop.pc, uop_pc);
    assert property (@(negedge clk) uop_fu == model_uop.fu)
        else report_mismatch("uop_fu", 32'(model_uop.fu), 32'(uop_fu));
    assert property (@(negedge clk) uop_op == model_uop.op)
        else report_mismatch("uop_op", 32'(model_uop.op), 32'(uop_op));
    assert property (@(negedge clk) uop_rs1 == model_uop.rs1)
        else report_mismatch("uop_rs1", 32'(model_uop.rs1), 32'(uop_rs1));
    assert property (@(negedge clk) uop_rs2 == model_uop.rs2)
        else report_mismatch("uop_rs2", 32'(model_uop.rs2), 32'(uop_rs2));
    assert property (@(negedge clk) uop_rd == model_uop.rd)
        else report_mismatch("uop_rd", 32'(model_uop.rd), 32'(uop_rd));
    assert property (@(negedge clk) uop_use_pc == model_uop.use_pc)
        else report_mismatch("uop_use_pc", 32'(model_uop.use_pc), 32'(uop_use_pc));
    assert property (@(negedge clk) uop_use_imm == model_uop.use_imm)
        else report_mismatch("uop_use_imm", 32'(model_uop.use_imm), 32'(uop_use_imm));
    assert property (@(negedge clk) uop_imm == model_uop.imm)
        else report_mismatch("uop_imm", model_uop.imm, uop_imm);

    // --------------------
    // stimulus
    // --------------------
    function automatic logic [OPCODE_W-1:0] kept_opcode(input logic [3:0] sel);
        logic [OPCODE_W-1:0] opc;
        case (sel)
            4'd0    : opc = RTYPE_OP;
            4'd1    : opc = ITYPE_OP;
            4'd2    : opc = LOAD_OP;
            4'd3    : opc = STYPE_OP;
            4'd4    : opc = BTYPE_OP;
            4'd5    : opc = JAL_OP;
            4'd6    : opc = JALR_OP;
            4'd7    : opc = LUI_OP;
            4'd8    : opc = AUIPC_OP;
            default : opc = SYSTEM_OP;
        endcase
        return opc;
    endfunction

    task automatic drive_fetch(input logic valid, input logic [INST_W-1:0] inst,
                               input logic [XLEN-1:0] pc);
        @(posedge clk);
        #1;
        fetch_valid = valid;
        fetch_inst  = inst;
        fetch_pc    = pc;
    endtask

    // known opcode on 10 of 16 draws
    // valid about 80 %
    task automatic drive_random_fetch();
        logic [31:0]       rnd;
        logic [INST_W-1:0] word;
        logic [XLEN-1:0]   pc;
        logic              valid;
        rnd  = $random(seed);
        word = $random(seed);
        pc   = $random(seed);
        if (rnd[3:0] < 4'd10) begin
            word[6:0] = kept_opcode(rnd[3:0]);
        end
        pc[1:0] = 2'b00;
        valid   = (rnd[31:8] % 24'd10) < 24'd8;
        drive_fetch(valid, word, pc);
    endtask

    initial begin
        seed        = 32'h8e51_995b;
        arst_n      = 1'b0;
        // a live fetch while reset is held must not reach the uop outputs
        fetch_valid = 1'b1;
        fetch_inst  = 32'h0010_0093;
        fetch_pc    = 32'h0000_0100;

        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        arst_n = 1'b1;

        repeat (RANDOM_CYCLES) drive_random_fetch();

        drive_fetch(1'b1, 32'h3020_0073, 32'h0000_1000);
        drive_fetch(1'b1, 32'h1050_0073, 32'h0000_1004);
        drive_fetch(1'b0, 32'h1050_0073, 32'h0000_1008);
        // no unit claims opcode 7f
        drive_fetch(1'b1, 32'h0000_007f, 32'h0000_100c);
        drive_fetch(1'b1, 32'h3420_2573, 32'h0000_1010);
        drive_fetch(1'b0, 32'h0000_0000, 32'h0000_0000);

        repeat (2) @(posedge clk);
        @(negedge clk);
        #1;

        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* source/rv_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_decoder import rv_decode_pkg::*; (
    input  wire logic              clk,
    input  wire logic              arst_n,
    input  wire logic              fetch_valid,
    input  wire logic [INST_W-1:0] fetch_inst,
    input  wire logic [XLEN-1:0]   fetch_pc,
    output logic                   uop_valid,
    output logic [XLEN-1:0]        uop_pc,
    output fu_t                    uop_fu,
    output op_t                    uop_op,
    output reg_t                   uop_rs1,
    output reg_t                   uop_rs2,
    output reg_t                   uop_rd,
    output logic                   uop_use_pc,
    output logic                   uop_use_imm,
    output logic [XLEN-1:0]        uop_imm
);

    logic            alu_hit;
    logic            lsu_hit;
    logic            bru_hit;
    logic            csr_hit;
    fu_t             alu_fu;
    op_t             alu_op;
    op_t             lsu_op;
    op_t             bru_op;
    op_t             csr_op;
    // {rs1_en, rs2_en, rd_en, use_pc, use_imm} per unit
    logic [4:0]      alu_flags;
    logic [4:0]      lsu_flags;
    logic [4:0]      bru_flags;
    logic [4:0]      csr_flags;
    logic [XLEN-1:0] imm;

    // --------------------
    // unit decoders
    // --------------------
    rv_alu_decode u_alu_decode (
        .inst    (fetch_inst),
        .hit     (alu_hit),
        .fu      (alu_fu),
        .op      (alu_op),
        .rs1_en  (alu_flags[4]),
        .rs2_en  (alu_flags[3]),
        .rd_en   (alu_flags[2]),
        .use_pc  (alu_flags[1]),
        .use_imm (alu_flags[0])
    );

    rv_lsu_decode u_lsu_decode (
        .inst    (fetch_inst),
        .hit     (lsu_hit),
        .op      (lsu_op),
        .rs1_en  (lsu_flags[4]),
        .rs2_en  (lsu_flags[3]),
        .rd_en   (lsu_flags[2]),
        .use_pc  (lsu_flags[1]),
        .use_imm (lsu_flags[0])
    );

    rv_bru_decode u_bru_decode (
        .inst    (fetch_inst),
        .hit     (bru_hit),
        .op      (bru_op),
        .rs1_en  (bru_flags[4]),
        .rs2_en  (bru_flags[3]),
        .rd_en   (bru_flags[2]),
        .use_pc  (bru_flags[1]),
        .use_imm (bru_flags[0])
    );

    rv_csr_decode u_csr_decode (
        .inst    (fetch_inst),
        .hit     (csr_hit),
        .op      (csr_op),
        .rs1_en  (csr_flags[4]),
        .rs2_en  (csr_flags[3]),
        .rd_en   (csr_flags[2]),
        .use_pc  (csr_flags[1]),
        .use_imm (csr_flags[0])
    );

    rv_imm_gen u_imm_gen (
        .inst (fetch_inst),
        .imm  (imm)
    );

    // --------------------
    // merge and register
    // --------------------
    rv_uop_merge u_uop_merge (
        .clk         (clk),
        .arst_n      (arst_n),
        .fetch_valid (fetch_valid),
        .fetch_inst  (fetch_inst),
        .fetch_pc    (fetch_pc),
        .alu_hit     (alu_hit),
        .alu_fu      (alu_fu),
        .alu_op      (alu_op),
        .alu_flags   (alu_flags),
        .lsu_hit     (lsu_hit),
        .lsu_op      (lsu_op),
        .lsu_flags   (lsu_flags),
        .bru_hit     (bru_hit),
        .bru_op      (bru_op),
        .bru_flags   (bru_flags),
        .csr_hit     (csr_hit),
        .csr_op      (csr_op),
        .csr_flags   (csr_flags),
        .imm         (imm),
        .uop_valid   (uop_valid),
        .uop_pc      (uop_pc),
        .uop_fu      (uop_fu),
        .uop_op      (uop_op),
        .uop_rs1     (uop_rs1),
        .uop_rs2     (uop_rs2),
        .uop_rd      (uop_rd),
        .uop_use_pc  (uop_use_pc),
        .uop_use_imm (uop_use_imm),
        .uop_imm     (uop_imm)
    );

endmodule

`default_nettype wire

/* source/rv_uop_merge.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_uop_merge import rv_decode_pkg::*; (
    input  wire logic              clk,
    input  wire logic              arst_n,
    input  wire logic              fetch_valid,
    input  wire logic [INST_W-1:0] fetch_inst,
    input  wire logic [XLEN-1:0]   fetch_pc,
    input  wire logic              alu_hit,
    input  wire fu_t               alu_fu,
    input  wire op_t               alu_op,
    input  wire logic [4:0]        alu_flags,
    input  wire logic              lsu_hit,
    input  wire op_t               lsu_op,
    input  wire logic [4:0]        lsu_flags,
    input  wire logic              bru_hit,
    input  wire op_t               bru_op,
    input  wire logic [4:0]        bru_flags,
    input  wire logic              csr_hit,
    input  wire op_t               csr_op,
    input  wire logic [4:0]        csr_flags,
    input  wire logic [XLEN-1:0]   imm,
    output logic                   uop_valid,
    output logic [XLEN-1:0]        uop_pc,
    output fu_t                    uop_fu,
    output op_t                    uop_op,
    output reg_t                   uop_rs1,
    output reg_t                   uop_rs2,
    output reg_t                   uop_rd,
    output logic                   uop_use_pc,
    output logic                   uop_use_imm
    ,output logic [XLEN-1:0]       uop_imm
);

    // flags are {rs1_en, rs2_en, rd_en, use_pc, use_imm}
    fu_t             sel_fu;
    op_t             sel_op;
    logic [4:0]      sel_flags;
    reg_t            nxt_rs1;
    reg_t            nxt_rs2;
    reg_t            nxt_rd;
    logic [XLEN-1:0] nxt_imm;

    // --------------------
    // unit select
    // --------------------
    always_comb begin
        sel_fu    = NONE;
        sel_op    = _ADD;
        sel_flags = '0;
        if (alu_hit) begin
            sel_fu    = alu_fu;
            sel_op    = alu_op;
            sel_flags = alu_flags;
        end else if (lsu_hit) begin
            sel_fu    = GLSU;
            sel_op    = lsu_op;
            sel_flags = lsu_flags;
        end else if (bru_hit) begin
            sel_fu    = BRU;
            sel_op    = bru_op;
            sel_flags = bru_flags;
        end else if (csr_hit) begin
            sel_fu    = CSR;
            sel_op    = csr_op;
            sel_flags = csr_flags;
        end
    end

    assign nxt_rs1 = sel_flags[4] ? reg_t'(fetch_inst[19:15]) : X0;
    assign nxt_rs2 = sel_flags[3] ? reg_t'(fetch_inst[24:20]) : X0;
    assign nxt_rd  = sel_flags[2] ? reg_t'(fetch_inst[11:7])  : X0;
    // use_imm is clear whenever no unit hits
    assign nxt_imm = sel_flags[0] ? imm : '0;

    // --------------------
    // output register
    // --------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            uop_valid   <= 1'b0;
            uop_pc      <= '0;
            uop_fu      <= NONE;
            uop_op      <= _ADD;
            uop_rs1     <= X0;
            uop_rs2     <= X0;
            uop_rd      <= X0;
            uop_use_pc  <= 1'b0;
            uop_use_imm <= 1'b0;
            uop_imm     <= '0;
        end else begin
            uop_valid   <= fetch_valid;
            uop_pc      <= fetch_valid ? fetch_pc : '0;
            uop_fu      <= fetch_valid ? sel_fu : NONE;
            uop_op      <= fetch_valid ? sel_op : _ADD;
            uop_rs1     <= fetch_valid ? nxt_rs1 : X0;
            uop_rs2     <= fetch_valid ? nxt_rs2 : X0;
            uop_rd      <= fetch_valid ? nxt_rd : X0;
            uop_use_pc  <= fetch_valid & sel_flags[1];
            uop_use_imm <= fetch_valid & sel_flags[0];
            uop_imm     <= fetch_valid ? nxt_imm : '0;
        end
    end

endmodule

`default_nettype wire

/* source/rv_imm_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_imm_gen import rv_decode_pkg::*; (
    input  wire logic [INST_W-1:0] inst,
    output logic [XLEN-1:0]        imm
);

    logic [OPCODE_W-1:0] opcode;
    logic [XLEN-1:0]     i_imm;
    logic [XLEN-1:0]     s_imm;
    logic [XLEN-1:0]     b_imm;
    logic [XLEN-1:0]     u_imm;
    logic [XLEN-1:0]     j_imm;

    assign opcode = inst[6:0];

    // --------------------
    // formats
    // --------------------
    assign i_imm = {{20{inst[31]}}, inst[31:20]};
    assign s_imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign b_imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    assign u_imm = {inst[31:12], 12'd0};
    assign j_imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        case (opcode)
            ITYPE_OP, LOAD_OP, JALR_OP, SYSTEM_OP : imm = i_imm;
            STYPE_OP                              : imm = s_imm;
            BTYPE_OP                              : imm = b_imm;
            LUI_OP, AUIPC_OP                      : imm = u_imm;
            JAL_OP                                : imm = j_imm;
            default                               : imm = '0;
        endcase
    end

endmodule

`default_nettype wire

/* source/rv_csr_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_csr_decode import rv_decode_pkg::*; (
    input  wire logic [INST_W-1:0] inst,
    output logic                   hit,
    output op_t                    op,
    output logic                   rs1_en,
    output logic                   rs2_en,
    output logic                   rd_en,
    output logic                   use_pc,
    output logic                   use_imm
);

    logic [OPCODE_W-1:0] opcode;
    logic [FUNCT3_W-1:0] f3;
    logic [11:0]         f12;

    assign opcode = inst[6:0];
    assign f3     = inst[14:12];
    assign f12    = inst[31:20];

    assign hit    = (opcode == SYSTEM_OP);
    // rs1 field carries the zimm value for the immediate forms
    assign rs1_en = hit;
    assign rs2_en = 1'b0;
    assign rd_en  = hit;
    assign use_pc = 1'b0;

    assign use_imm = hit && (f3 inside {CSRRWI_FUNCT3, CSRRSI_FUNCT3, CSRRCI_FUNCT3});

    always_comb begin
        op = _ADD;
        if (hit) begin
            case (f3)
                CSRRW_FUNCT3, CSRRWI_FUNCT3 : op = _CSRRW;
                CSRRS_FUNCT3, CSRRSI_FUNCT3 : op = _CSRRS;
                CSRRC_FUNCT3, CSRRCI_FUNCT3 : op = _CSRRC;
                PRIV_FUNCT3 : begin
                    if (f12 == MRET_FUNCT12) begin
                        op = _MRET;
                    end else if (f12 == WFI_FUNCT12) begin
                        op = _WFI;
                    end
                end
                default : op = _ADD;
            endcase
        end
    end

endmodule

`default_nettype wire

/* source/rv_bru_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_bru_decode import rv_decode_pkg::*; (
    input  wire logic [INST_W-1:0] inst,
    output logic                   hit,
    output op_t                    op,
    output logic                   rs1_en,
    output logic                   rs2_en,
    output logic                   rd_en,
    output logic                   use_pc,
    output logic                   use_imm
);

    logic [OPCODE_W-1:0] opcode;
    logic [FUNCT3_W-1:0] f3;
    logic                is_br;
    logic                is_jal;
    logic                is_jalr;

    assign opcode  = inst[6:0];
    assign f3      = inst[14:12];
    assign is_br   = (opcode == BTYPE_OP);
    assign is_jal  = (opcode == JAL_OP);
    assign is_jalr = (opcode == JALR_OP);

    assign hit     = is_br | is_jal | is_jalr;
    assign rs1_en  = is_br | is_jalr;
    assign rs2_en  = is_br;
    assign rd_en   = is_jal | is_jalr;
    assign use_pc  = is_jal | is_jalr;
    // target offset travels as the immediate
    assign use_imm = hit;

    always_comb begin
        op = _ADD;
        if (is_jal) begin
            op = _JAL;
        end else if (is_jalr) begin
            op = _JALR;
        end else if (is_br) begin
            case (f3)
                BEQ_FUNCT3  : op = _EQ;
                BNE_FUNCT3  : op = _NE;
                BLT_FUNCT3  : op = _LT;
                BGE_FUNCT3  : op = _GE;
                BLTU_FUNCT3 : op = _LTU;
                BGEU_FUNCT3 : op = _GEU;
                default     : op = _ADD;
            endcase
        end
    end

endmodule

`default_nettype wire

/* source/rv_lsu_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_lsu_decode import rv_decode_pkg::*; (
    input  wire logic [INST_W-1:0] inst,
    output logic                   hit,
    output op_t                    op,
    output logic                   rs1_en,
    output logic                   rs2_en,
    output logic                   rd_en,
    output logic                   use_pc,
    output logic                   use_imm
);

    logic [OPCODE_W-1:0] opcode;
    logic [FUNCT3_W-1:0] f3;
    logic                is_load;
    logic                is_store;

    assign opcode   = inst[6:0];
    assign f3       = inst[14:12];
    assign is_load  = (opcode == LOAD_OP);
    assign is_store = (opcode == STYPE_OP);

    assign hit     = is_load | is_store;
    assign rs1_en  = hit;
    assign rs2_en  = is_store;
    assign rd_en   = is_load;
    assign use_pc  = 1'b0;
    // address offset always comes from the immediate
    assign use_imm = hit;

    always_comb begin
        op = _ADD;
        if (is_load) begin
            case (f3)
                LB_FUNCT3  : op = _LB;
                LH_FUNCT3  : op = _LH;
                LW_FUNCT3  : op = _LW;
                LBU_FUNCT3 : op = _LBU;
                LHU_FUNCT3 : op = _LHU;
                default    : op = _ADD;
            endcase
        end else if (is_store) begin
            case (f3)
                SB_FUNCT3 : op = _SB;
                SH_FUNCT3 : op = _SH;
                SW_FUNCT3 : op = _SW;
                default   : op = _ADD;
            endcase
        end
    end

endmodule

`default_nettype wire

/* source/rv_alu_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_alu_decode import rv_decode_pkg::*; (
    input  wire logic [INST_W-1:0] inst,
    output logic                   hit,
    output fu_t                    fu,
    output op_t                    op,
    output logic                   rs1_en,
    output logic                   rs2_en,
    output logic                   rd_en,
    output logic                   use_pc,
    output logic                   use_imm
);

    logic [OPCODE_W-1:0] opcode;
    logic [FUNCT3_W-1:0] f3;
    logic                f7_mul;
    logic                f7_alt;

    assign opcode = inst[6:0];
    assign f3     = inst[14:12];
    assign f7_mul = inst[25];
    assign f7_alt = inst[30];

    always_comb begin
        hit     = 1'b0;
        fu      = NONE;
        op      = _ADD;
        rs1_en  = 1'b0;
        rs2_en  = 1'b0;
        rd_en   = 1'b0;
        use_pc  = 1'b0;
        use_imm = 1'b0;

        case (opcode)
            RTYPE_OP : begin
                hit    = 1'b1;
                fu     = f7_mul ? GMUL : GALU;
                rs1_en = 1'b1;
                rs2_en = 1'b1;
                rd_en  = 1'b1;

                case ({f7_mul, f3})
                    {1'b0, ADD_FUNCT3 } : op = f7_alt ? _SUB : _ADD;
                    {1'b0, SLL_FUNCT3 } : op = _SLL;
                    {1'b0, SLT_FUNCT3 } : op = _LT;
                    {1'b0, SLTU_FUNCT3} : op = _LTU;
                    {1'b0, XOR_FUNCT3 } : op = _XOR;
                    {1'b0, SRL_FUNCT3 } : op = f7_alt ? _SRA : _SRL;
                    {1'b0, OR_FUNCT3  } : op = _OR;
                    {1'b0, AND_FUNCT3 } : op = _AND;
                    {1'b1, ADD_FUNCT3 } : op = _MUL;
                    {1'b1, SLL_FUNCT3 } : op = _MULH;
                    {1'b1, SLT_FUNCT3 } : op = _MULHSU;
                    {1'b1, SLTU_FUNCT3} : op = _MULHU;
                    // div/rem group is not supported
                    default             : op = _ADD;
                endcase
            end

            ITYPE_OP : begin
                hit     = 1'b1;
                fu      = GALU;
                rs1_en  = 1'b1;
                rd_en   = 1'b1;
                use_imm = 1'b1;

                case (f3)
                    SLL_FUNCT3  : op = _SLL;
                    SLT_FUNCT3  : op = _LT;
                    SLTU_FUNCT3 : op = _LTU;
                    XOR_FUNCT3  : op = _XOR;
                    SRL_FUNCT3  : op = f7_alt ? _SRA : _SRL;
                    OR_FUNCT3   : op = _OR;
                    AND_FUNCT3  : op = _AND;
                    default     : op = _ADD;
                endcase
            end

            LUI_OP, AUIPC_OP : begin
                hit     = 1'b1;
                fu      = GALU;
                rd_en   = 1'b1;
                use_imm = 1'b1;
                use_pc  = (opcode == AUIPC_OP);
            end

            default : ;
        endcase
    end

endmodule

`default_nettype wire

/* source/rv_decode_pkg.sv */
`default_nettype none

package rv_decode_pkg;

    // --------------------
    // widths
    // --------------------
    localparam int XLEN     = 32;
    localparam int INST_W   = 32;
    localparam int REG_W    = 5;
    localparam int OPCODE_W = 7;
    localparam int FUNCT3_W = 3;

    typedef logic [REG_W-1:0] reg_t;

    localparam reg_t X0 = '0;

    // --------------------
    // opcodes
    // --------------------
    localparam logic [OPCODE_W-1:0] RTYPE_OP  = 7'b0110011;
    localparam logic [OPCODE_W-1:0] ITYPE_OP  = 7'b0010011;
    localparam logic [OPCODE_W-1:0] LOAD_OP   = 7'b0000011;
    localparam logic [OPCODE_W-1:0] STYPE_OP  = 7'b0100011;
    localparam logic [OPCODE_W-1:0] BTYPE_OP  = 7'b1100011;
    localparam logic [OPCODE_W-1:0] JAL_OP    = 7'b1101111;
    localparam logic [OPCODE_W-1:0] JALR_OP   = 7'b1100111;
    localparam logic [OPCODE_W-1:0] LUI_OP    = 7'b0110111;
    localparam logic [OPCODE_W-1:0] AUIPC_OP  = 7'b0010111;
    localparam logic [OPCODE_W-1:0] SYSTEM_OP = 7'b1110011;

    // --------------------
    // funct3 / funct12
    // --------------------
    localparam logic [FUNCT3_W-1:0] ADD_FUNCT3  = 3'b000;
    localparam logic [FUNCT3_W-1:0] SLL_FUNCT3  = 3'b001;
    localparam logic [FUNCT3_W-1:0] SLT_FUNCT3  = 3'b010;
    localparam logic [FUNCT3_W-1:0] SLTU_FUNCT3 = 3'b011;
    localparam logic [FUNCT3_W-1:0] XOR_FUNCT3  = 3'b100;
    localparam logic [FUNCT3_W-1:0] SRL_FUNCT3  = 3'b101;
    localparam logic [FUNCT3_W-1:0] OR_FUNCT3   = 3'b110;
    localparam logic [FUNCT3_W-1:0] AND_FUNCT3  = 3'b111;

    localparam logic [FUNCT3_W-1:0] LB_FUNCT3  = 3'b000;
    localparam logic [FUNCT3_W-1:0] LH_FUNCT3  = 3'b001;
    localparam logic [FUNCT3_W-1:0] LW_FUNCT3  = 3'b010;
    localparam logic [FUNCT3_W-1:0] LBU_FUNCT3 = 3'b100;
    localparam logic [FUNCT3_W-1:0] LHU_FUNCT3 = 3'b101;

    localparam logic [FUNCT3_W-1:0] SB_FUNCT3 = 3'b000;
    localparam logic [FUNCT3_W-1:0] SH_FUNCT3 = 3'b001;
    localparam logic [FUNCT3_W-1:0] SW_FUNCT3 = 3'b010;

    localparam logic [FUNCT3_W-1:0] BEQ_FUNCT3  = 3'b000;
    localparam logic [FUNCT3_W-1:0] BNE_FUNCT3  = 3'b001;
    localparam logic [FUNCT3_W-1:0] BLT_FUNCT3  = 3'b100;
    localparam logic [FUNCT3_W-1:0] BGE_FUNCT3  = 3'b101;
    localparam logic [FUNCT3_W-1:0] BLTU_FUNCT3 = 3'b110;
    localparam logic [FUNCT3_W-1:0] BGEU_FUNCT3 = 3'b111;

    localparam logic [FUNCT3_W-1:0] PRIV_FUNCT3   = 3'b000;
    localparam logic [FUNCT3_W-1:0] CSRRW_FUNCT3  = 3'b001;
    localparam logic [FUNCT3_W-1:0] CSRRS_FUNCT3  = 3'b010;
    localparam logic [FUNCT3_W-1:0] CSRRC_FUNCT3  = 3'b011;
    localparam logic [FUNCT3_W-1:0] CSRRWI_FUNCT3 = 3'b101;
    localparam logic [FUNCT3_W-1:0] CSRRSI_FUNCT3 = 3'b110;
    localparam logic [FUNCT3_W-1:0] CSRRCI_FUNCT3 = 3'b111;

    localparam logic [11:0] MRET_FUNCT12 = 12'h302;
    localparam logic [11:0] WFI_FUNCT12  = 12'h105;

    // --------------------
    // micro-op encodings
    // --------------------
    // zero values of both enums form the idle micro-op
    typedef enum logic [2:0] {
        NONE, GALU, GMUL, GLSU, BRU, CSR
    } fu_t;

    typedef enum logic [5:0] {
        _ADD, _SUB, _SLL, _LT, _LTU, _XOR, _SRL, _SRA, _OR, _AND,
        _MUL, _MULH, _MULHSU, _MULHU,
        _LB, _LH, _LW, _LBU, _LHU, _SB, _SH, _SW,
        _EQ, _NE, _GE, _GEU,
        _JAL, _JALR,
        _CSRRW, _CSRRS, _CSRRC, _MRET, _WFI
    } op_t;

endpackage

`default_nettype wire
